// ==== hdl/countIf.sv ====
`timescale 1ns/10ps

interface countIf;
    import sifhPkg::*;

    logic   valid;
    pixel_t pixel;
    bin_t   bin;
    count_t count;      // Bin count after this hit
    logic   passStart;
    logic   passEnd;

    // Source reads its own outputs back for write-back and forwarding
    modport src (
        output valid, pixel, bin, count, passStart, passEnd
    );

    modport dst (
        input valid, pixel, bin, count, passStart, passEnd
    );

endinterface

// ==== hdl/dataFilter.sv ====
`timescale 1ns/10ps

module dataFilter (
    input  logic             clk,
    input  logic             combin_res,
    input  logic             wrEn,
    input  sifhPkg::stamp_t  data,
    input  sifhPkg::pixel_t  pixel,
    input  sifhPkg::pass_e   pass,
    input  logic             first,
    input  logic             last,
    input  sifhPkg::stamp_t  winLow [sifhPkg::PIXEL_NUM],
    sampleIf.src             smp
);
    import sifhPkg::*;

    // Accepted sample with its sequencer tags
    logic   wrEnQ;
    stamp_t dataQ;
    pixel_t pixelQ;
    pass_e  passQ;
    logic   firstQ;
    logic   lastQ;

    stamp_t curLow;
    stamp_t offset;     // Distance above the window edge
    logic   inWin;
    bin_t   binNext;
    logic   keep;

    // ************************************************************************
    // Input stage
    // ************************************************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            wrEnQ <= 1'b0;
        end else begin
            wrEnQ <= wrEn;
        end
    end

    always_ff @(posedge clk) begin
        dataQ  <= data;
        pixelQ <= pixel;
        passQ  <= pass;     // Pass before the toggle on the last sample
        firstQ <= first;
        lastQ  <= last;
    end

    always_comb begin
        curLow = winLow[pixelQ];
        offset = dataQ - curLow;
        inWin  = (dataQ >= curLow) && (offset < stamp_t'(BIN_NUM));
        if (passQ == COARSE) begin
            binNext = dataQ[Np-1 -: Nb];    // Top bits only
            keep    = 1'b1;
        end else begin
            binNext = offset[Nb-1:0];
            keep    = inWin;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            smp.valid     <= 1'b0;
            smp.passStart <= 1'b0;
            smp.passEnd   <= 1'b0;
        end else begin
            smp.valid     <= wrEnQ && keep;
            smp.passStart <= wrEnQ && firstQ;
            smp.passEnd   <= wrEnQ && lastQ;
        end
    end

    always_ff @(posedge clk) begin
        smp.pixel <= pixelQ;
        smp.bin   <= binNext;
    end

endmodule

// ==== hdl/frameSequencer.sv ====
`timescale 1ns/10ps

module frameSequencer (
    input  logic             clk,
    input  logic             combin_res,
    input  logic             wrEn,
    output sifhPkg::pixel_t  pixel,
    output sifhPkg::pass_e   pass,
    output logic             first,
    output logic             last
);
    import sifhPkg::*;

    logic [$clog2(DATA_NUM)-1:0] smpCnt;    // Sample within pixel
    pixel_t                      pixCnt;
    logic [$clog2(ACQ_NUM)-1:0]  acqCnt;

    logic smpWrap;
    logic pixWrap;
    logic acqWrap;

    assign smpWrap = (smpCnt == DATA_NUM - 1);
    assign pixWrap = (pixCnt == PIXEL_NUM - 1);
    assign acqWrap = (acqCnt == ACQ_NUM - 1);

    // Qualify the sample currently on the input
    assign first = (smpCnt == '0) && (pixCnt == '0) && (acqCnt == '0);
    assign last  = smpWrap && pixWrap && acqWrap;
    assign pixel = pixCnt;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            smpCnt <= '0;
            pixCnt <= '0;
            acqCnt <= '0;
            pass   <= COARSE;
        end else if (wrEn) begin
            smpCnt <= smpWrap ? '0 : smpCnt + 1'b1;
            if (smpWrap) begin
                pixCnt <= pixWrap ? '0 : pixCnt + 1'b1;
                if (pixWrap) begin
                    acqCnt <= acqWrap ? '0 : acqCnt + 1'b1;
                end
            end
            if (last) begin
                pass <= (pass == COARSE) ? FINE : COARSE;   // Next pass starts
            end
        end
    end

endmodule

// ==== hdl/histBuilder.sv ====
`timescale 1ns/10ps

module histBuilder (
    input  logic clk,
    input  logic combin_res,
    sampleIf.dst smp,
    countIf.src  cnt
);
    import sifhPkg::*;

    count_t                       mem [ENTRY_NUM];
    logic [ENTRY_NUM-1:0]         occupied;     // Entry touched in this pass
    logic [$clog2(ENTRY_NUM)-1:0] addr;
    logic [$clog2(ENTRY_NUM)-1:0] wbAddr;
    logic                         fwd;
    logic                         hit;
    count_t                       base;
    count_t                       countNext;

    assign addr   = {smp.pixel, smp.bin};
    assign wbAddr = {cnt.pixel, cnt.bin};

    // ************************************************************************
    // Read, forward and increment
    // ************************************************************************
    always_comb begin
        // Memory lags one cycle behind the registered count
        fwd       = cnt.valid && (wbAddr == addr) && !smp.passStart;
        hit       = !smp.passStart && occupied[addr];
        base      = fwd ? cnt.count : mem[addr];
        countNext = hit ? base + 1'b1 : count_t'(1);   // First touch starts at 1
    end

    // Write-back of the previous result
    always_ff @(posedge clk) begin
        if (cnt.valid) begin
            mem[wbAddr] <= cnt.count;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            occupied      <= '0;
            cnt.valid     <= 1'b0;
            cnt.passStart <= 1'b0;
            cnt.passEnd   <= 1'b0;
        end else begin
            if (smp.passStart) begin
                occupied <= '0;     // Lazy clear of the whole histogram
            end
            if (smp.valid) begin
                occupied[addr] <= 1'b1;
            end
            cnt.valid     <= smp.valid;
            cnt.passStart <= smp.passStart;
            cnt.passEnd   <= smp.passEnd;
        end
    end

    always_ff @(posedge clk) begin
        cnt.pixel <= smp.pixel;
        cnt.bin   <= smp.bin;
        cnt.count <= countNext;
    end

endmodule

// ==== hdl/peakDetector.sv ====
`timescale 1ns/10ps

module peakDetector (
    input  logic            clk,
    input  logic            combin_res,
    countIf.dst             cnt,
    output sifhPkg::bin_t   peakBin [sifhPkg::PIXEL_NUM],
    output logic            peaksReady,
    output sifhPkg::pass_e  pass            // Pass that produced these peaks
);
    import sifhPkg::*;

    count_t maxCnt [PIXEL_NUM];

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            maxCnt     <= '{default: '0};
            peakBin    <= '{default: '0};
            peaksReady <= 1'b0;
            pass       <= FINE;     // As if a fine pass had just ended
        end else begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                if (cnt.valid && (cnt.pixel == pixel_t'(p)) &&
                    (cnt.passStart || (cnt.count > maxCnt[p]))) begin
                    maxCnt[p]  <= cnt.count;    // Strictly greater keeps first to reach
                    peakBin[p] <= cnt.bin;
                end else if (cnt.passStart) begin
                    maxCnt[p]  <= '0;
                    peakBin[p] <= '0;
                end
            end
            peaksReady <= cnt.passEnd;
            if (cnt.passEnd) begin
                pass <= (pass == COARSE) ? FINE : COARSE;
            end
        end
    end

endmodule

// ==== hdl/sampleIf.sv ====
`timescale 1ns/10ps

interface sampleIf;
    import sifhPkg::*;

    logic   valid;      // Low for a dropped sample
    pixel_t pixel;
    bin_t   bin;
    logic   passStart;  // Travels even when valid is low
    logic   passEnd;

    modport src (
        output valid, pixel, bin, passStart, passEnd
    );

    modport dst (
        input valid, pixel, bin, passStart, passEnd
    );

endinterface

// ==== hdl/sifhPkg.sv ====
package sifhPkg;

    // ************************************************************************
    // Widths and counts
    // ************************************************************************
    localparam int Np        = 10;              // Timestamp width
    localparam int Nb        = 5;               // Bin address width
    localparam int PIXEL_NUM = 4;
    localparam int DATA_NUM  = 2;               // Samples per pixel per acquisition
    localparam int ACQ_NUM   = 4;               // Acquisitions per pass
    localparam int BIN_NUM   = 2 ** Nb;
    localparam int CNT_W     = 4;               // Holds DATA_NUM * ACQ_NUM hits

    // Histogram entries over all pixels
    localparam int ENTRY_NUM = PIXEL_NUM * BIN_NUM;

    // Fine window placement
    localparam int HALF_WIN    = 2 ** (Nb - 1);
    localparam int WIN_MAX_LOW = 2 ** Np - 2 ** Nb;   // Keeps window inside code range

    // ************************************************************************
    // Types
    // ************************************************************************
    typedef logic [Np-1:0]    stamp_t;
    typedef logic [Nb-1:0]    bin_t;
    typedef logic [1:0]       pixel_t;
    typedef logic [CNT_W-1:0] count_t;

    typedef enum logic {
        COARSE,
        FINE
    } pass_e;

endpackage

// ==== hdl/sifhTop.sv ====
`timescale 1ns/10ps

module sifhTop (
    input  logic                                          clk,
    input  logic                                          combin_res,
    input  logic                                          wrEn,
    input  sifhPkg::stamp_t                               data,
    output logic [sifhPkg::PIXEL_NUM*sifhPkg::Np-1:0]     result,
    output logic                                          resultValid
);
    import sifhPkg::*;

    pixel_t pixel;
    pass_e  seqPass;        // Live pass from the sequencer
    pass_e  peakPass;       // Pass tagged through the pipeline
    logic   first;
    logic   last;
    logic   peaksReady;
    stamp_t winLow    [PIXEL_NUM];
    stamp_t resultArr [PIXEL_NUM];
    bin_t   peakBin   [PIXEL_NUM];

    sampleIf smpBus ();
    countIf  cntBus ();

    frameSequencer seq_i (
        .clk, .combin_res, .wrEn,
        .pixel, .pass(seqPass), .first, .last
    );

    dataFilter filt_i (
        .clk, .combin_res, .wrEn, .data,
        .pixel, .pass(seqPass), .first, .last,
        .winLow, .smp(smpBus.src)
    );

    histBuilder hist_i (
        .clk, .combin_res, .smp(smpBus.dst), .cnt(cntBus.src)
    );

    peakDetector peak_i (
        .clk, .combin_res, .cnt(cntBus.dst),
        .peakBin, .peaksReady, .pass(peakPass)
    );

    windowCalc win_i (
        .clk, .combin_res, .peakBin, .peaksReady, .pass(peakPass),
        .winLow, .result(resultArr), .resultValid
    );

    // Pixel 0 in the low bits
    always_comb begin
        for (int p = 0; p < PIXEL_NUM; p++) begin
            result[p*Np +: Np] = resultArr[p];
        end
    end

endmodule

// ==== hdl/windowCalc.sv ====
`timescale 1ns/10ps

module windowCalc (
    input  logic             clk,
    input  logic             combin_res,
    input  sifhPkg::bin_t    peakBin [sifhPkg::PIXEL_NUM],
    input  logic             peaksReady,
    input  sifhPkg::pass_e   pass,
    output sifhPkg::stamp_t  winLow [sifhPkg::PIXEL_NUM],
    output sifhPkg::stamp_t  result [sifhPkg::PIXEL_NUM],
    output logic             resultValid
);
    import sifhPkg::*;

    stamp_t centre  [PIXEL_NUM];
    stamp_t lowEdge [PIXEL_NUM];
    stamp_t winNext [PIXEL_NUM];

    // ************************************************************************
    // Window placement from coarse peaks
    // ************************************************************************
    always_comb begin
        for (int p = 0; p < PIXEL_NUM; p++) begin
            centre[p]  = stamp_t'(peakBin[p]) << (Np - Nb);
            lowEdge[p] = centre[p] - stamp_t'(HALF_WIN);
            if (centre[p] < stamp_t'(HALF_WIN)) begin
                winNext[p] = '0;                    // Clamp at bottom
            end else if (lowEdge[p] > stamp_t'(WIN_MAX_LOW)) begin
                winNext[p] = stamp_t'(WIN_MAX_LOW);  // Clamp at top
            end else begin
                winNext[p] = lowEdge[p];
            end
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            winLow      <= '{default: '0};
            result      <= '{default: '0};
            resultValid <= 1'b0;
        end else begin
            resultValid <= 1'b0;
            if (peaksReady && (pass == COARSE)) begin
                winLow <= winNext;
            end
            if (peaksReady && (pass == FINE)) begin
                for (int p = 0; p < PIXEL_NUM; p++) begin
                    result[p] <= winLow[p] + stamp_t'(peakBin[p]);  // Back to absolute code
                end
                resultValid <= 1'b1;
            end
        end
    end

endmodule

// ==== sifhTop.f ====
hdl/sifhPkg.sv
hdl/sampleIf.sv
hdl/countIf.sv
hdl/frameSequencer.sv
hdl/dataFilter.sv
hdl/histBuilder.sv
hdl/peakDetector.sv
hdl/windowCalc.sv
hdl/sifhTop.sv
tb/sifhTb.sv

// ==== tb/sifhTb.sv ====
`timescale 1ns/10ps

module sifhTb;
    import sifhPkg::*;

    localparam int PASS_LEN = PIXEL_NUM * DATA_NUM * ACQ_NUM;
    localparam int TIMEOUT  = 50;

    logic                    clk;
    logic                    combin_res;
    logic                    wrEn;
    stamp_t                  data;
    logic [PIXEL_NUM*Np-1:0] result;
    logic                    resultValid;

    logic [31:0] seed = 32'hfcf4_bf65;
    logic [31:0] savedSeed;
    int          errCnt   = 0;
    int          checkCnt = 0;
    logic        pulseOk  = 1'b0;       // resultValid may be high
    stamp_t      centre    [PIXEL_NUM];
    stamp_t      coarseBuf [PASS_LEN];
    stamp_t      fineBuf   [PASS_LEN];
    stamp_t      mWin      [PIXEL_NUM]; // Model windows
    stamp_t      mRes      [PIXEL_NUM];
    stamp_t      savedRes  [PIXEL_NUM];
    int          tieOfs    [8];         // Offsets per acquisition and sample

    sifhTop dut_i (
        .clk, .combin_res, .wrEn, .data, .result, .resultValid
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic expectTrue(input logic ok, input string msg);
        checkCnt++;
        assert (ok) else begin
            errCnt++;
            $display("error at %0t ns: %s", $time, msg);
        end
    endtask

    // No pulse outside the end of a fine pass
    always @(negedge clk) begin
        assert (!resultValid || pulseOk) else begin
            errCnt++;
            $display("error at %0t ns: resultValid outside a fine pass end", $time);
        end
    end

    // ************************************************************************
    // Stimulus generation
    // ************************************************************************
    task automatic fillCluster(input int coarseSpread, input int fineSpread);
        int pix;
        for (int i = 0; i < PASS_LEN; i++) begin
            pix          = (i / DATA_NUM) % PIXEL_NUM;
            coarseBuf[i] = centre[pix] + stamp_t'(nextRand() % coarseSpread)
                           - stamp_t'(coarseSpread / 2);
            fineBuf[i]   = centre[pix] + stamp_t'(nextRand() % fineSpread)
                           - stamp_t'(fineSpread / 2);  // Wide spread drops some
        end
    endtask

    task automatic fillTie();
        int pix;
        int k;
        for (int i = 0; i < PASS_LEN; i++) begin
            pix          = (i / DATA_NUM) % PIXEL_NUM;
            k            = (i / (DATA_NUM * PIXEL_NUM)) * DATA_NUM + i % DATA_NUM;
            coarseBuf[i] = centre[pix] + stamp_t'(tieOfs[k]);
            fineBuf[i]   = coarseBuf[i];
        end
    endtask

    // ************************************************************************
    // Reference model of one pass
    // ************************************************************************
    task automatic modelPass(input logic isFine);
        int     hist   [PIXEL_NUM][BIN_NUM];
        int     maxCnt [PIXEL_NUM];
        int     peak   [PIXEL_NUM];
        int     pix;
        int     b;
        int     ctr;
        stamp_t s;
        for (int p = 0; p < PIXEL_NUM; p++) begin
            maxCnt[p] = 0;
            peak[p]   = 0;
            for (int j = 0; j < BIN_NUM; j++) begin
                hist[p][j] = 0;
            end
        end
        for (int i = 0; i < PASS_LEN; i++) begin
            pix = (i / DATA_NUM) % PIXEL_NUM;
            s   = isFine ? fineBuf[i] : coarseBuf[i];
            b   = isFine ? int'(s) - int'(mWin[pix]) : int'(s) >> (Np - Nb);
            if (b >= 0 && b < BIN_NUM) begin    // Outside the fine window
                hist[pix][b]++;
                if (hist[pix][b] > maxCnt[pix]) begin
                    maxCnt[pix] = hist[pix][b];
                    peak[pix]   = b;
                end
            end
        end
        for (int p = 0; p < PIXEL_NUM; p++) begin
            ctr = peak[p] * 2 ** (Np - Nb);
            if (isFine) begin
                mRes[p] = mWin[p] + stamp_t'(peak[p]);
            end else if (ctr < HALF_WIN) begin
                mWin[p] = '0;
            end else if (ctr - HALF_WIN > WIN_MAX_LOW) begin
                mWin[p] = stamp_t'(WIN_MAX_LOW);
            end else begin
                mWin[p] = stamp_t'(ctr - HALF_WIN);
            end
        end
    endtask

    task automatic drivePass(input logic isFine, input int gapPct);
        for (int i = 0; i < PASS_LEN; i++) begin
            for (int g = 0; g < 3 && (nextRand() % 100) < gapPct; g++) begin
                @(posedge clk);
                wrEn <= 1'b0;
            end
            @(posedge clk);
            wrEn <= 1'b1;
            data <= isFine ? fineBuf[i] : coarseBuf[i];
        end
        @(posedge clk);
        wrEn <= 1'b0;
    endtask

    task automatic checkResult();
        int n;
        n       = 0;
        pulseOk = 1'b1;
        @(negedge clk);
        while (!resultValid && n < TIMEOUT) begin
            n++;
            @(negedge clk);
        end
        if (!resultValid) begin
            $display("Timed out after %0d cycles waiting for resultValid", TIMEOUT);
            $display("Checks: %0d, errors: %0d", checkCnt, errCnt + 1);
            $display("TEST FAILED");
            $finish;
        end else begin
            expectTrue(n == 4, $sformatf("resultValid %0d edges after last sample", n));
            for (int p = 0; p < PIXEL_NUM; p++) begin
                expectTrue(result[p*Np +: Np] == mRes[p],
                    $sformatf("pixel %0d result %0d, expected %0d",
                              p, result[p*Np +: Np], mRes[p]));
            end
            @(negedge clk);
            expectTrue(!resultValid, "resultValid wider than one cycle");
            @(posedge clk);
            pulseOk = 1'b0;
        end
    endtask

    task automatic runFrame(input int gapPct);
        modelPass(1'b0);
        drivePass(1'b0, gapPct);
        repeat (6) @(posedge clk);
        modelPass(1'b1);
        drivePass(1'b1, gapPct);
        checkResult();
        repeat (6) @(posedge clk);
    endtask

    // ************************************************************************
    // Main sequence
    // ************************************************************************
    initial begin
        tieOfs     = '{3, 3, 7, 7, 7, 1, 3, 9};  // Bin 7 reaches three first
        mWin       = '{default: '0};
        combin_res = 1'b0;
        wrEn       = 1'b0;
        data       = '0;
        repeat (8) @(posedge clk);
        combin_res <= 1'b1;
        expectTrue(!resultValid, "resultValid high after reset");
        repeat (4) @(posedge clk);

        centre    = '{10'd100, 10'd350, 10'd600, 10'd900};
        savedSeed = seed;
        fillCluster(16, 24);
        runFrame(0);
        for (int p = 0; p < PIXEL_NUM; p++) begin
            savedRes[p] = result[p*Np +: Np];
        end
        centre = '{10'd700, 10'd60, 10'd300, 10'd850};    // Second frame
        fillCluster(20, 40);
        runFrame(0);
        centre = '{10'd8, 10'd1015, 10'd500, 10'd200};    // Bins 0 and 31
        fillCluster(8, 96);
        runFrame(0);
        centre = '{10'd132, 10'd260, 10'd516, 10'd772};
        fillTie();
        runFrame(0);

        // First frame again with idle gaps
        centre = '{10'd100, 10'd350, 10'd600, 10'd900};
        seed   = savedSeed;
        fillCluster(16, 24);
        runFrame(30);
        for (int p = 0; p < PIXEL_NUM; p++) begin
            expectTrue(result[p*Np +: Np] == savedRes[p],
                $sformatf("pixel %0d result differs from gap-free run", p));
        end

        $display("Checks: %0d, errors: %0d", checkCnt, errCnt);
        if (errCnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
